// ==== src.f ====
common/avr_core_pkg.sv
common/avr_isa_pkg.sv
core/avr_regfile.sv
core/avr_decode.sv
core/avr_execute.sv
core/avr_core.sv
bench/avr_core_sva.sv
bench/avr_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module avr_core_tb -o avr_core_sim

out=$(./obj_dir/avr_core_sim 2>&1) || true
echo "$out"

# the run passes only if the testbench printed its pass line
echo "$out" | grep -q "^Finished with no errors$"

// ==== bench/avr_core_tb.sv ====
/*
 * testbench for the two-stage core
 * - clock, reset, registered program memory and data memory
 * - random program generator for six instruction groups
 * - ISA-level reference model predicting the data write and read streams
 * - stream comparison with per-test and closing report
 */
`timescale 1ns/10ps

module avr_core_tb import avr_core_pkg::*;;

	localparam word_t HALT = 16'hCFFF;
	localparam int TIMEOUT = 4000;

	// register-register opcodes, bits 15 to 10
	localparam logic [5:0] OP_ADD = 6'b000011;
	localparam logic [5:0] OP_ADC = 6'b000111;
	localparam logic [5:0] OP_SUB = 6'b000110;
	localparam logic [5:0] OP_SBC = 6'b000010;
	localparam logic [5:0] OP_AND = 6'b001000;
	localparam logic [5:0] OP_OR = 6'b001010;
	localparam logic [5:0] OP_EOR = 6'b001001;
	localparam logic [5:0] OP_MOV = 6'b001011;
	localparam logic [5:0] OP_CP = 6'b000101;
	localparam logic [5:0] OP_CPC = 6'b000001;
	// immediate opcodes, bits 15 to 12
	localparam logic [3:0] OP_CPI = 4'h3;
	localparam logic [3:0] OP_SBCI = 4'h4;
	localparam logic [3:0] OP_SUBI = 4'h5;
	localparam logic [3:0] OP_ORI = 4'h6;
	localparam logic [3:0] OP_ANDI = 4'h7;
	localparam logic [3:0] OP_LDI = 4'hE;

	logic clk;
	logic reset;
	word_t pc;
	word_t cdata;
	word_t data_addr;
	logic data_wen;
	logic data_ren;
	byte_t data_write;
	byte_t data_read;

	word_t pmem [256];
	byte_t dmem [256];
	// reference model state
	byte_t mdmem [256];
	byte_t mreg [32];
	sreg_t msreg;

	word_t exp_addr [$];
	byte_t exp_data [$];
	word_t obs_addr [$];
	byte_t obs_data [$];
	// load addresses and the bytes returned for them
	word_t exp_raddr [$];
	byte_t exp_rdata [$];
	word_t obs_raddr [$];
	byte_t obs_rdata [$];

	int seed;
	int errors;
	int test_errs;
	int checks;
	int tests;
	int pw;
	int halt_at;
	int out_addr;
	int marker;

	// outputs latched mid-cycle where they are stable
	word_t pc_n;
	word_t addr_n;
	logic wen_n;
	logic ren_n;
	byte_t wd_n;

	avr_core #(.RESET_PC(16'h0000)) dut (
		.clk(clk), .reset(reset), .pc(pc), .cdata(cdata),
		.data_addr(data_addr), .data_wen(data_wen), .data_ren(data_ren),
		.data_write(data_write), .data_read(data_read)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(negedge clk) begin
		pc_n = pc;
		addr_n = data_addr;
		wen_n = data_wen;
		ren_n = data_ren;
		wd_n = data_write;
	end

	// program word and read data land 2 ns after the edge
	always @(posedge clk) begin
		#2;
		cdata = pmem[pc_n[7:0]];
		if (ren_n === 1'b1) begin
			data_read = dmem[addr_n[7:0]];
			obs_raddr.push_back(addr_n);
			obs_rdata.push_back(data_read);
		end
		if (wen_n === 1'b1) begin
			dmem[addr_n[7:0]] = wd_n;
			obs_addr.push_back(addr_n);
			obs_data.push_back(wd_n);
		end
	end

	function automatic int rnd(input int n);
		rnd = int'($unsigned($random(seed)) % n);
	endfunction

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (exp !== got) begin
			errors++;
			test_errs++;
			$display("Mismatch at %0t: %s expected %0h got %0h", $time, what, exp, got);
		end
	endtask

	task automatic finish_run();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	// instruction encoders
	task automatic emit(input word_t w);
		pmem[pw] = w;
		pw = pw + 1;
	endtask

	task automatic emit_rr(input logic [5:0] op, input int d, input int r);
		logic [4:0] d5;
		logic [4:0] r5;
		d5 = 5'(d);
		r5 = 5'(r);
		emit({op, r5[4], d5, r5[3:0]});
	endtask

	task automatic emit_imm(input logic [3:0] op, input int d, input byte_t k);
		logic [3:0] d4;
		d4 = 4'(d - 16);
		emit({op, k[7:4], d4, k[3:0]});
	endtask

	task automatic emit_br(input logic clear, input int bitn, input int off);
		emit({5'b11110, clear, 7'(off), 3'(bitn)});
	endtask

	// st set gives STS, clear gives LDS
	task automatic emit_ls(input logic st, input int d, input int a);
		logic [4:0] d5;
		d5 = 5'(d);
		emit({6'b100100, st, d5, 4'h0});
		emit(word_t'(a));
	endtask

	task automatic emit_sts(input int d);
		emit_ls(1'b1, d, out_addr);
		out_addr++;
	endtask

	function automatic logic [5:0] rand_rr_op(input int n);
		case (rnd(n))
			0: rand_rr_op = OP_ADD;
			1: rand_rr_op = OP_ADC;
			2: rand_rr_op = OP_SUB;
			3: rand_rr_op = OP_SBC;
			4: rand_rr_op = OP_AND;
			5: rand_rr_op = OP_OR;
			6: rand_rr_op = OP_EOR;
			7: rand_rr_op = OP_MOV;
			8: rand_rr_op = OP_CP;
			default: rand_rr_op = OP_CPC;
		endcase
	endfunction

	// taken path and fall-through path each store their own marker via r17
	task automatic emit_marker_branch(input int bitn);
		emit_br(1'(rnd(2)), bitn, 4);
		emit_imm(OP_LDI, 17, byte_t'(marker));
		emit_sts(17);
		emit({4'hC, 12'd3});
		emit_imm(OP_LDI, 17, byte_t'(marker + 1));
		emit_sts(17);
		marker += 2;
	endtask

	// model ALU, kind 0 add, 1 sub, 2 and, 3 or, 4 eor, 5 move
	task automatic model_alu(input int kind, input logic usec, input logic wr,
			input int d, input byte_t b);
		byte_t a;
		byte_t r;
		logic cin;
		logic c;
		logic v;
		logic z;
		a = mreg[d];
		cin = usec & msreg[FLAG_C];
		c = msreg[FLAG_C];
		v = 1'b0;
		case (kind)
			0: begin
				r = a + b + {7'd0, cin};
				c = (a[7] & b[7]) | (b[7] & ~r[7]) | (~r[7] & a[7]);
				v = (a[7] & b[7] & ~r[7]) | (~a[7] & ~b[7] & r[7]);
			end
			1: begin
				r = a - b - {7'd0, cin};
				c = (~a[7] & b[7]) | (b[7] & r[7]) | (r[7] & ~a[7]);
				v = (a[7] & ~b[7] & ~r[7]) | (~a[7] & b[7] & r[7]);
			end
			2: r = a & b;
			3: r = a | b;
			4: r = a ^ b;
			default: r = b;
		endcase
		if (kind != 5) begin
			z = (r == 8'h00);
			// carry-using subtracts only keep a zero
			if (kind == 1 && usec)
				z = z & msreg[FLAG_Z];
			msreg = {3'b000, r[7] ^ v, v, r[7], z, c};
		end
		if (wr)
			mreg[d] = r;
	endtask

	task automatic run_model();
		int p;
		int steps;
		int d;
		int r;
		int bitn;
		word_t w;
		word_t a;
		byte_t k;
		logic fl;
		p = 0;
		steps = 0;
		msreg = '0;
		while (steps < TIMEOUT) begin
			w = pmem[p[7:0]];
			if (w == HALT)
				break;
			steps++;
			d = int'(w[8:4]);
			r = int'({w[9], w[3:0]});
			k = {w[11:8], w[3:0]};
			if (w[15:12] == OP_LDI) begin
				mreg[16 + int'(w[7:4])] = k;
				p = p + 1;
			end else if (w[15:12] == 4'hC) begin
				p = p + 1 + int'($signed(w[11:0]));
			end else if (w[15:11] == 5'b11110) begin
				bitn = int'(w[2:0]);
				// H, T and I do not exist and test as zero
				fl = (bitn < 5) ? msreg[bitn] : 1'b0;
				p = p + 1;
				if (fl != w[10])
					p = p + int'($signed(w[9:3]));
			end else if (w[15:10] == 6'b100100) begin
				a = pmem[8'(p + 1)];
				if (w[9]) begin
					exp_addr.push_back(a);
					exp_data.push_back(mreg[d]);
					mdmem[a[7:0]] = mreg[d];
				end else begin
					exp_raddr.push_back(a);
					exp_rdata.push_back(mdmem[a[7:0]]);
					mreg[d] = mdmem[a[7:0]];
				end
				p = p + 2;
			end else if (w[15:14] == 2'b00 && w[15:12] != OP_CPI) begin
				case (w[15:10])
					OP_ADD: model_alu(0, 1'b0, 1'b1, d, mreg[r]);
					OP_ADC: model_alu(0, 1'b1, 1'b1, d, mreg[r]);
					OP_SUB: model_alu(1, 1'b0, 1'b1, d, mreg[r]);
					OP_SBC: model_alu(1, 1'b1, 1'b1, d, mreg[r]);
					OP_CP: model_alu(1, 1'b0, 1'b0, d, mreg[r]);
					OP_CPC: model_alu(1, 1'b1, 1'b0, d, mreg[r]);
					OP_AND: model_alu(2, 1'b0, 1'b1, d, mreg[r]);
					OP_OR: model_alu(3, 1'b0, 1'b1, d, mreg[r]);
					OP_EOR: model_alu(4, 1'b0, 1'b1, d, mreg[r]);
					default: model_alu(5, 1'b0, 1'b1, d, mreg[r]);
				endcase
				p = p + 1;
			end else begin
				d = 16 + int'(w[7:4]);
				case (w[15:12])
					OP_CPI: model_alu(1, 1'b0, 1'b0, d, k);
					OP_SBCI: model_alu(1, 1'b1, 1'b1, d, k);
					OP_SUBI: model_alu(1, 1'b0, 1'b1, d, k);
					OP_ORI: model_alu(3, 1'b0, 1'b1, d, k);
					OP_ANDI: model_alu(2, 1'b0, 1'b1, d, k);
				endcase
				p = p + 1;
			end
		end
		if (steps >= TIMEOUT) begin
			errors++;
			test_errs++;
			$display("reference model never reached the end of the program");
		end
	endtask

	// hold reset, clear memories and load every register with a known value
	task automatic begin_test();
		@(posedge clk);
		#2;
		reset = 1'b1;
		pw = 0;
		out_addr = 0;
		marker = 1;
		test_errs = 0;
		exp_addr.delete();
		exp_data.delete();
		exp_raddr.delete();
		exp_rdata.delete();
		for (int i = 0; i < 256; i++) begin
			pmem[i] = HALT;
			dmem[i] = byte_t'((i * 29) ^ (tests * 53 + 7));
			mdmem[i] = dmem[i];
		end
		for (int i = 16; i < 32; i++)
			emit_imm(OP_LDI, i, byte_t'(rnd(256)));
		for (int i = 0; i < 16; i++)
			emit_rr(OP_MOV, i, 16 + rnd(16));
	endtask

	task automatic run_test(input string name);
		int cycles;
		int n;
		int nr;
		halt_at = pw;
		emit(HALT);
		run_model();
		repeat (4) @(posedge clk);
		#2;
		obs_addr.delete();
		obs_data.delete();
		obs_raddr.delete();
		obs_rdata.delete();
		reset = 1'b0;
		cycles = 0;
		while (pc != word_t'(halt_at) && cycles <= TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		tests++;
		if (cycles > TIMEOUT) begin
			errors++;
			$display("test %0d %s: core stalled, pc never reached the end of the program",
				tests, name);
		end else begin
			// let the last store leave the pipeline
			repeat (4) @(negedge clk);
			check($sformatf("%s write count", name), exp_addr.size(), obs_addr.size());
			n = (exp_addr.size() < obs_addr.size()) ? exp_addr.size() : obs_addr.size();
			for (int i = 0; i < n; i++) begin
				check($sformatf("%s write %0d address", name, i),
					32'(exp_addr[i]), 32'(obs_addr[i]));
				check($sformatf("%s write %0d data", name, i),
					32'(exp_data[i]), 32'(obs_data[i]));
			end
			check($sformatf("%s read count", name), exp_raddr.size(), obs_raddr.size());
			nr = (exp_raddr.size() < obs_raddr.size()) ? exp_raddr.size() : obs_raddr.size();
			for (int i = 0; i < nr; i++) begin
				check($sformatf("%s read %0d address", name, i),
					32'(exp_raddr[i]), 32'(obs_raddr[i]));
				check($sformatf("%s read %0d data", name, i),
					32'(exp_rdata[i]), 32'(obs_rdata[i]));
			end
			$display("test %0d %s: %0d writes, %0d reads, %0d errors",
				tests, name, n, nr, test_errs);
		end
	endtask

	initial begin
		seed = 32'hb30e;
		errors = 0;
		checks = 0;
		tests = 0;
		reset = 1'b1;
		cdata = '0;
		data_read = '0;

		begin_test();
		for (int i = 0; i < 8; i++)
			emit_imm(OP_LDI, 16 + rnd(16), byte_t'(rnd(256)));
		for (int i = 0; i < 12; i++)
			emit_sts(16 + rnd(16));
		run_test("ldi_sts");

		begin_test();
		begin
			int d;
			d = 16;
			for (int i = 0; i < 30; i++) begin
				// about half the ops reuse the previous destination
				if (rnd(2) == 0) begin
					if (rnd(2) == 0 || d < 16)
						d = 16 + rnd(16);
					emit_imm(4'(3 + rnd(5)), d, byte_t'(rnd(256)));
				end else begin
					if (rnd(2) == 0)
						d = rnd(32);
					emit_rr(rand_rr_op(10), d, rnd(32));
				end
			end
		end
		for (int i = 0; i < 32; i++)
			emit_sts(i);
		run_test("alu_forwarding");

		begin_test();
		for (int i = 0; i < 14; i++) begin
			if (rnd(2) == 0)
				emit_rr(OP_CP, rnd(32), rnd(32));
			else
				emit_imm(OP_CPI, 16 + rnd(16), byte_t'(rnd(256)));
			emit_marker_branch(rnd(8));
		end
		run_test("branch_flags");

		begin_test();
		for (int i = 0; i < 6; i++) begin
			int x;
			int y;
			x = rnd(256);
			y = rnd(256);
			emit_imm(OP_LDI, 20, byte_t'(x));
			emit_imm(OP_LDI, 21, byte_t'(rnd(2) == 0 ? x : rnd(256)));
			emit_rr(OP_CP, 20, 21);
			emit_imm(OP_LDI, 22, byte_t'(y));
			emit_imm(OP_LDI, 23, byte_t'(rnd(2) == 0 ? y : rnd(256)));
			emit_rr(OP_CPC, 22, 23);
			emit_marker_branch(FLAG_Z);
			emit_rr(OP_SBC, 24, 25);
			emit_sts(24);
			emit_rr(OP_ADC, 26, 27);
			emit_sts(26);
			emit_imm(OP_SBCI, 28, byte_t'(rnd(256)));
			emit_sts(28);
			emit_marker_branch(rnd(2) == 0 ? FLAG_C : FLAG_Z);
		end
		run_test("carry_chain");

		begin_test();
		for (int i = 0; i < 8; i++) begin
			int d;
			d = rnd(32);
			emit_ls(1'b0, d, 128 + rnd(128));
			emit_rr(rand_rr_op(7), d, rnd(32));
			emit_sts(d);
		end
		run_test("lds_use");

		begin_test();
		for (int i = 0; i < 4; i++) begin
			int m;
			m = 1 + rnd(4);
			emit({4'hC, 12'(2 * m)});
			// skipped stores aim above the checked range
			for (int j = 0; j < m; j++)
				emit_ls(1'b1, rnd(32), 96 + j);
			emit_sts(rnd(32));
		end
		run_test("rjmp_skip");

		finish_run();
	end

endmodule

// ==== bench/avr_core_sva.sv ====
/*
 * bound assertions for the core
 * - data strobes mutually exclusive and single-cycle
 * - strobes low and pc at the reset address around reset
 */
`timescale 1ns/10ps

module avr_core_sva import avr_core_pkg::*; #(
	parameter word_t RESET_PC = 16'h0000
) (
	input logic  clk,
	input logic  reset,
	input word_t pc,
	input logic  data_wen,
	input logic  data_ren
);

	// a read and a write never share a cycle
	a_strobe_excl: assert property (@(posedge clk) disable iff (reset)
		!(data_wen && data_ren)) else $error("data_wen and data_ren high together");

	a_reset_quiet: assert property (@(posedge clk)
		reset |=> (!data_wen && !data_ren)) else $error("data strobe high during reset");

	// first fetch after reset comes from the reset address
	a_reset_pc: assert property (@(posedge clk)
		$fell(reset) |-> (pc == RESET_PC)) else $error("pc not at reset address");

	a_strobe_pulse: assert property (@(posedge clk) disable iff (reset)
		!(data_wen && $past(data_wen)) && !(data_ren && $past(data_ren)))
		else $error("data strobe high for two cycles");

endmodule

bind avr_core avr_core_sva #(.RESET_PC(RESET_PC)) u_sva (
	.clk(clk), .reset(reset), .pc(pc), .data_wen(data_wen), .data_ren(data_ren)
);

// ==== core/avr_core.sv ====
/*
 * two-stage AVR-compatible core, top level
 * - program counter and next fetch address
 * - decode, execute and register file wiring
 * - data-port outputs from the decode stage
 */
`timescale 1ns/10ps

module avr_core import avr_core_pkg::*, avr_isa_pkg::*; #(
	parameter word_t RESET_PC = 16'h0000
) (
	input  logic   clk,
	input  logic   reset,
	output word_t  pc,
	input  word_t  cdata,
	output word_t  data_addr,
	output logic   data_wen,
	output logic   data_ren,
	output byte_t  data_write,
	input  byte_t  data_read
);

	// address of the word now on cdata
	word_t reg_pc;
	word_t next_pc;

	reg_sel_t rd_sel;
	reg_sel_t rr_sel;
	alu_op_e alu_op;
	logic use_carry;
	logic use_imm;
	byte_t imm;
	logic store;
	reg_sel_t dest;
	logic hold_pc;
	logic branch;
	word_t branch_offset;

	sreg_t next_sreg;
	byte_t result;
	byte_t rd_val;
	byte_t rr_val;
	logic wen;
	reg_sel_t waddr;
	byte_t wdata;

	// hold refetches the current word, a jump lands with no bubble
	always_comb begin
		if (hold_pc)
			next_pc = reg_pc;
		else if (branch)
			next_pc = reg_pc + 16'd1 + branch_offset;
		else
			next_pc = reg_pc + 16'd1;
	end

	assign pc = next_pc;

	always_ff @(posedge clk) begin
		if (reset)
			reg_pc <= RESET_PC;
		else
			reg_pc <= next_pc;
	end

	avr_decode u_decode (
		.clk(clk), .reset(reset), .cdata(cdata), .data_read(data_read),
		.next_sreg(next_sreg), .result(result),
		.rd_sel(rd_sel), .rr_sel(rr_sel),
		.alu_op(alu_op), .use_carry(use_carry), .use_imm(use_imm), .imm(imm),
		.store(store), .dest(dest),
		.hold_pc(hold_pc), .branch(branch), .branch_offset(branch_offset),
		.data_addr(data_addr), .data_wen(data_wen), .data_ren(data_ren),
		.data_write(data_write)
	);

	avr_execute u_execute (
		.clk(clk), .reset(reset),
		.alu_op(alu_op), .use_carry(use_carry), .use_imm(use_imm), .imm(imm),
		.store(store), .dest(dest), .rd_val(rd_val), .rr_val(rr_val),
		.result(result), .next_sreg(next_sreg),
		.wen(wen), .waddr(waddr), .wdata(wdata)
	);

	avr_regfile u_regfile (
		.clk(clk), .rd_sel(rd_sel), .rr_sel(rr_sel),
		.wen(wen), .waddr(waddr), .wdata(wdata),
		.rd_val(rd_val), .rr_val(rr_val)
	);

endmodule

// ==== core/avr_execute.sv ====
/*
 * second pipeline stage
 * - operation register between decode and execute
 * - 8-bit ALU with C, Z, N, V and S generation
 * - status register
 * - register file write port
 */
`timescale 1ns/10ps

module avr_execute import avr_core_pkg::*, avr_isa_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  alu_op_e   alu_op,
	input  logic      use_carry,
	input  logic      use_imm,
	input  byte_t     imm,
	input  logic      store,
	input  reg_sel_t  dest,
	input  byte_t     rd_val,
	input  byte_t     rr_val,
	output byte_t     result,
	output sreg_t     next_sreg,
	output logic      wen,
	output reg_sel_t  waddr,
	output byte_t     wdata
);

	alu_op_e op_q;
	logic store_q;
	logic carry_q;
	logic use_imm_q;
	byte_t imm_q;
	reg_sel_t dest_q;
	sreg_t sreg;

	byte_t opb;
	logic cin;
	logic [8:0] wide;
	logic flag_c;
	logic flag_v;
	logic flag_z;

	always_ff @(posedge clk) begin
		if (reset) begin
			op_q <= ALU_PASS;
			store_q <= 1'b0;
			sreg <= '0;
		end else begin
			op_q <= alu_op;
			store_q <= store;
			sreg <= next_sreg;
		end
	end

	always_ff @(posedge clk) begin
		carry_q <= use_carry;
		use_imm_q <= use_imm;
		imm_q <= imm;
		dest_q <= dest;
	end

	// operand B is the constant or Rr, A is always Rd
	assign opb = use_imm_q ? imm_q : rr_val;
	assign cin = carry_q & sreg[FLAG_C];

	always_comb begin
		wide = '0;
		result = opb;
		flag_c = sreg[FLAG_C];
		flag_v = 1'b0;
		case (op_q)
			ALU_ADD: begin
				wide = {1'b0, rd_val} + {1'b0, opb} + {8'd0, cin};
				result = wide[7:0];
				flag_c = wide[8];
				// same operand signs, different result sign
				flag_v = (rd_val[7] == opb[7]) && (result[7] != rd_val[7]);
			end
			ALU_SUB: begin
				wide = {1'b0, rd_val} - {1'b0, opb} - {8'd0, cin};
				result = wide[7:0];
				// bit 8 of the difference is the borrow
				flag_c = wide[8];
				flag_v = (rd_val[7] != opb[7]) && (result[7] != rd_val[7]);
			end
			ALU_AND: result = rd_val & opb;
			ALU_OR: result = rd_val | opb;
			ALU_EOR: result = rd_val ^ opb;
			default: result = opb;
		endcase

		// SBC, SBCI and CPC can only keep Z, never set it
		flag_z = (result == 8'h00);
		if (op_q == ALU_SUB && carry_q)
			flag_z = flag_z & sreg[FLAG_Z];

		next_sreg = sreg;
		if (op_q != ALU_PASS) begin
			next_sreg[FLAG_C] = flag_c;
			next_sreg[FLAG_Z] = flag_z;
			next_sreg[FLAG_N] = result[7];
			next_sreg[FLAG_V] = flag_v;
			next_sreg[FLAG_S] = result[7] ^ flag_v;
		end
	end

	// write lands at the end of this cycle, regfile forwards it
	assign wen = store_q;
	assign waddr = dest_q;
	assign wdata = result;

endmodule

// ==== core/avr_decode.sv ====
/*
 * first pipeline stage
 * - instruction classification and field extraction
 * - register read selects and operation for the execute stage
 * - RJMP and BRBS/BRBC next-address control
 * - LDS/STS sequencer with the registered data-port request
 */
`timescale 1ns/10ps

module avr_decode import avr_core_pkg::*, avr_isa_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  word_t     cdata,
	input  byte_t     data_read,
	input  sreg_t     next_sreg,
	input  byte_t     result,
	output reg_sel_t  rd_sel,
	output reg_sel_t  rr_sel,
	output alu_op_e   alu_op,
	output logic      use_carry,
	output logic      use_imm,
	output byte_t     imm,
	output logic      store,
	output reg_sel_t  dest,
	output logic      hold_pc,
	output logic      branch,
	output word_t     branch_offset,
	output word_t     data_addr,
	output logic      data_wen,
	output logic      data_ren,
	output byte_t     data_write
);

	step_e step;
	step_e next_step;
	// low until the first fetch after reset has returned
	logic primed;
	word_t held_op;
	word_t opcode;
	insn_class_e cls;
	logic next_wen;
	logic next_ren;

	// opcode fields
	reg_sel_t op_rd;
	reg_sel_t op_rr;
	reg_sel_t op_rdi;
	byte_t op_k;
	word_t simm12;
	word_t simm7;
	logic br_taken;

	// multi-word instructions keep working on the first word
	assign opcode = (step == STEP_FIRST) ? cdata : held_op;

	assign op_rd = opcode[FLD_RD_LSB +: 5];
	assign op_rr = {opcode[FLD_RR_HI], opcode[3:0]};
	assign op_rdi = reg_sel_t'(IMM_REG_BASE) + reg_sel_t'(opcode[FLD_RD_LSB +: 4]);
	assign op_k = {opcode[11:8], opcode[3:0]};
	assign simm12 = {{4{opcode[11]}}, opcode[11:0]};
	assign simm7 = {{9{opcode[FLD_SIMM7_LSB + 6]}}, opcode[FLD_SIMM7_LSB +: 7]};

	// flags of the instruction now in execute, bits 5-7 are zero
	assign br_taken = next_sreg[opcode[FLD_BR_BIT_LSB +: 3]] != opcode[FLD_BR_CLEAR];

	always_comb begin
		casez (opcode[15:10])
			6'b000001, 6'b00001?, 6'b000101, 6'b00011?, 6'b0010??:
				cls = CLS_ALU_RR;
			6'b0011??, 6'b01????:
				cls = CLS_ALU_IMM;
			6'b1110??:
				cls = CLS_LDI;
			6'b1100??:
				cls = CLS_RJMP;
			6'b11110?:
				cls = CLS_BRANCH;
			6'b100100: begin
				if (opcode[3:0] != 4'b0000)
					cls = CLS_NOP;
				else if (opcode[FLD_STORE])
					cls = CLS_STS;
				else
					cls = CLS_LDS;
			end
			default:
				cls = CLS_NOP;
		endcase
	end

	always_comb begin
		// default is a bubble that writes nothing
		rd_sel = op_rd;
		rr_sel = op_rr;
		alu_op = ALU_PASS;
		use_carry = 1'b0;
		use_imm = 1'b0;
		imm = op_k;
		store = 1'b0;
		dest = op_rd;
		hold_pc = 1'b0;
		branch = 1'b0;
		branch_offset = simm12;
		next_step = step;
		next_wen = 1'b0;
		next_ren = 1'b0;

		if (!primed) begin
			// refetch the reset address
			hold_pc = 1'b1;
		end else begin
			case (step)
				STEP_FIRST: begin
					case (cls)
						CLS_ALU_RR: begin
							store = 1'b1;
							case (opcode[13:10])
								// CPC and CP only touch the flags
								4'b0001: begin
									alu_op = ALU_SUB;
									use_carry = 1'b1;
									store = 1'b0;
								end
								4'b0010: begin
									alu_op = ALU_SUB;
									use_carry = 1'b1;
								end
								4'b0011: alu_op = ALU_ADD;
								4'b0101: begin
									alu_op = ALU_SUB;
									store = 1'b0;
								end
								4'b0110: alu_op = ALU_SUB;
								4'b0111: begin
									alu_op = ALU_ADD;
									use_carry = 1'b1;
								end
								4'b1000: alu_op = ALU_AND;
								4'b1001: alu_op = ALU_EOR;
								4'b1010: alu_op = ALU_OR;
								default: alu_op = ALU_PASS;
							endcase
						end
						CLS_ALU_IMM: begin
							rd_sel = op_rdi;
							dest = op_rdi;
							use_imm = 1'b1;
							store = 1'b1;
							case (opcode[14:12])
								// CPI
								3'b011: begin
									alu_op = ALU_SUB;
									store = 1'b0;
								end
								3'b100: begin
									alu_op = ALU_SUB;
									use_carry = 1'b1;
								end
								3'b101: alu_op = ALU_SUB;
								3'b110: alu_op = ALU_OR;
								default: alu_op = ALU_AND;
							endcase
						end
						CLS_LDI: begin
							dest = op_rdi;
							use_imm = 1'b1;
							store = 1'b1;
						end
						CLS_RJMP: begin
							branch = 1'b1;
						end
						CLS_BRANCH: begin
							branch = br_taken;
							branch_offset = simm7;
						end
						CLS_LDS: begin
							next_step = STEP_ADDR;
						end
						CLS_STS: begin
							// Rd passes through the ALU to become the write data
							rr_sel = op_rd;
							next_step = STEP_ADDR;
						end
						default: begin
						end
					endcase
				end
				STEP_ADDR: begin
					// cdata now carries the data address
					if (cls == CLS_STS) begin
						next_wen = 1'b1;
						next_step = STEP_FIRST;
					end else begin
						next_ren = 1'b1;
						hold_pc = 1'b1;
						next_step = STEP_LOAD;
					end
				end
				default: begin
					if (data_ren) begin
						// read strobe is out, data returns next cycle
						hold_pc = 1'b1;
					end else begin
						// write the loaded byte like an LDI to the full Rd
						use_imm = 1'b1;
						imm = data_read;
						store = 1'b1;
						next_step = STEP_FIRST;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			step <= STEP_FIRST;
			primed <= 1'b0;
			data_wen <= 1'b0;
			data_ren <= 1'b0;
		end else begin
			step <= next_step;
			primed <= 1'b1;
			data_wen <= next_wen;
			data_ren <= next_ren;
		end
	end

	always_ff @(posedge clk) begin
		if (step == STEP_FIRST)
			held_op <= cdata;
		if (next_wen || next_ren)
			data_addr <= cdata;
		// result holds the STS source register in the address cycle
		if (next_wen)
			data_write <= result;
	end

endmodule

// ==== core/avr_regfile.sv ====
/*
 * 32 x 8 register file
 * - two registered read ports
 * - one write port, forwarded to a read of the same register
 */
`timescale 1ns/10ps

module avr_regfile import avr_core_pkg::*; (
	input  logic      clk,
	input  reg_sel_t  rd_sel,
	input  reg_sel_t  rr_sel,
	input  logic      wen,
	input  reg_sel_t  waddr,
	input  byte_t     wdata,
	output byte_t     rd_val,
	output byte_t     rr_val
);

	byte_t regs [REG_COUNT];

	always_ff @(posedge clk) begin
		if (wen)
			regs[waddr] <= wdata;

		// a back-to-back dependent instruction sees the new value
		if (wen && waddr == rd_sel)
			rd_val <= wdata;
		else
			rd_val <= regs[rd_sel];

		if (wen && waddr == rr_sel)
			rr_val <= wdata;
		else
			rr_val <= regs[rr_sel];
	end

endmodule

// ==== common/avr_isa_pkg.sv ====
/*
 * instruction set definitions
 * - ALU operation encoding
 * - decoded instruction classes
 * - LDS/STS sequencer states
 * - opcode field positions and the immediate register base
 */
package avr_isa_pkg;

	// ALU_PASS moves operand B through and leaves the flags alone
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_PASS
	} alu_op_e;

	typedef enum logic [2:0] {
		CLS_ALU_RR,
		CLS_ALU_IMM,
		CLS_LDI,
		CLS_RJMP,
		CLS_BRANCH,
		CLS_LDS,
		CLS_STS,
		CLS_NOP
	} insn_class_e;

	// first word, address word, load data return
	typedef enum logic [1:0] {
		STEP_FIRST,
		STEP_ADDR,
		STEP_LOAD
	} step_e;

	// immediate forms only reach r16 to r31
	localparam int IMM_REG_BASE = 16;

	// Rd field, five bits or the low four for the immediate forms
	localparam int FLD_RD_LSB = 4;
	// top bit of Rr in the register-register forms
	localparam int FLD_RR_HI = 9;
	// set for STS, clear for LDS
	localparam int FLD_STORE = 9;
	// set for BRBC, clear for BRBS
	localparam int FLD_BR_CLEAR = 10;
	// status bit number tested by a branch
	localparam int FLD_BR_BIT_LSB = 0;
	// seven-bit branch displacement
	localparam int FLD_SIMM7_LSB = 3;

endpackage

// ==== common/avr_core_pkg.sv ====
/*
 * core-wide data path types
 * - word, byte, register number and status register typedefs
 * - register file depth
 * - status flag bit positions inside the status register
 */
package avr_core_pkg;

	localparam int WORD_BITS = 16;
	localparam int BYTE_BITS = 8;
	localparam int REG_COUNT = 32;

	// instructions, program addresses and data addresses
	typedef logic [WORD_BITS-1:0] word_t;
	// register contents and data memory bytes
	typedef logic [BYTE_BITS-1:0] byte_t;
	// register number, r0 to r31
	typedef logic [$clog2(REG_COUNT)-1:0] reg_sel_t;
	// status register, bits 5 to 7 always read as zero
	typedef logic [BYTE_BITS-1:0] sreg_t;

	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 2;
	localparam int FLAG_V = 3;
	localparam int FLAG_S = 4;

endpackage
